/* mrp_rx_out.f */
+incdir+.
mrp_rx_out_pkg.sv
mrp_rx_desc_fifo.sv
mrp_rx_buffer_mem.sv
mrp_rx_buffer_output_ctrl.sv
mrp_rx_buffer_output_datap.sv
mrp_rx_buffer_output.sv
tb_mrp_rx_buffer_output.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -f mrp_rx_out.f --top-module tb_mrp_rx_buffer_output -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
fi
exit $status

/* tb_mrp_rx_buffer_output.sv */
`default_nettype none

`include "mrp_rx_out_cfg.svh"

module tb_mrp_rx_buffer_output;

    localparam int NUM_MSGS = 200;
    localparam int MAX_CYCLES = 20000;  // 200 x (16 + 16*3 + 8) = 14400, rounded up
    localparam logic [31:0] SEED = 32'd70;

    logic                    clk;
    logic                    rst;
    logic                    wr_en;
    mrp_rx_out_pkg::addr_t   wr_addr;
    mrp_rx_out_pkg::line_t   wr_data;
    logic                    desc_push;
    mrp_rx_out_pkg::addr_t   desc_base;
    mrp_rx_out_pkg::len_t    desc_len;
    mrp_rx_out_pkg::msg_id_t desc_msg_id;
    logic                    desc_full;
    logic                    meta_val;
    logic                    meta_rdy = 1'b0;
    mrp_rx_out_pkg::msg_id_t meta_msg_id;
    mrp_rx_out_pkg::len_t    meta_len;
    logic                    data_val;
    logic                    data_rdy = 1'b0;
    mrp_rx_out_pkg::line_t   data;

    // ********************
    // model state
    // ********************

    mrp_rx_out_pkg::line_t   model_mem [0:(1 << `MRP_ADDR_W)-1];
    mrp_rx_out_pkg::msg_id_t exp_id_q [$];
    mrp_rx_out_pkg::len_t    exp_len_q [$];
    mrp_rx_out_pkg::line_t   exp_line_q [$];

    logic [31:0] prod_state = SEED;
    logic [31:0] rdy_state = SEED ^ 32'h9e3779b9;  // second stream for the ready lines
    int          total_lines = 0;
    int          lines_seen = 0;
    int          cycles = 0;
    int          fifo_level = 0;  // descriptors pushed, not yet popped
    logic        pushed_any = 1'b0;
    logic        meta_val_d = 1'b0;
    logic        meta_wait = 1'b0;  // val high, not taken last cycle
    logic        data_wait = 1'b0;
    mrp_rx_out_pkg::msg_id_t held_id;
    mrp_rx_out_pkg::len_t    held_len;
    mrp_rx_out_pkg::line_t   held_data;

    mrp_rx_buffer_output uut (
        .clk         (clk),
        .rst         (rst),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .desc_push   (desc_push),
        .desc_base   (desc_base),
        .desc_len    (desc_len),
        .desc_msg_id (desc_msg_id),
        .desc_full   (desc_full),
        .meta_val    (meta_val),
        .meta_rdy    (meta_rdy),
        .meta_msg_id (meta_msg_id),
        .meta_len    (meta_len),
        .data_val    (data_val),
        .data_rdy    (data_rdy),
        .data        (data)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] rand_word();
        prod_state = lcg_next(prod_state);
        return prod_state;
    endfunction

    task automatic fail_msg(input string what);
        $display("%0t: %s", $time, what);
        $display("Test failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %0t %s got %0b expected %0b", $time, name, got, exp);
            $display("Test failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic check_meta(input mrp_rx_out_pkg::msg_id_t got_id,
                              input mrp_rx_out_pkg::len_t got_len,
                              input mrp_rx_out_pkg::msg_id_t exp_id,
                              input mrp_rx_out_pkg::len_t exp_len);
        if (got_id !== exp_id) begin
            $display("ERROR %0t meta_msg_id got %0h expected %0h", $time, got_id, exp_id);
            $display("Test failed");
            $fatal(1, "metadata mismatch");
        end else if (got_len !== exp_len) begin
            $display("ERROR %0t meta_len got %0d expected %0d", $time, got_len, exp_len);
            $display("Test failed");
            $fatal(1, "metadata mismatch");
        end
    endtask

    task automatic check_data(input mrp_rx_out_pkg::line_t got, input mrp_rx_out_pkg::line_t exp);
        if (got !== exp) begin
            $display("ERROR %0t data got %0h expected %0h", $time, got, exp);
            $display("Test failed");
            $fatal(1, "data mismatch");
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        rdy_state = lcg_next(rdy_state);
        meta_rdy <= (rdy_state[31:24] < 8'd154);  // about 60 percent
        rdy_state = lcg_next(rdy_state);
        data_rdy <= (rdy_state[31:24] < 8'd154);
    end

    always @(posedge clk) begin
        mrp_rx_out_pkg::ctrl_state_e st;
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            st = uut.output_ctrl.state_reg;
            $display("timeout after %0d cycles with %0d of %0d lines out, controller in %s",
                     cycles, lines_seen, total_lines, st.name());
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    // ********************
    // output monitor
    // ********************

    // negedge, so val, rdy and payload are settled for the coming edge
    always @(negedge clk) begin
        if (!rst) begin
            if (!pushed_any) begin
                check_bit("meta_val", meta_val, 1'b0);
                check_bit("data_val", data_val, 1'b0);
                check_bit("desc_full", desc_full, 1'b0);
            end
            if (desc_push) pushed_any = 1'b1;

            // each pop starts a new metadata offer
            if (meta_val && !meta_val_d) fifo_level = fifo_level - 1;
            check_bit("desc_full", desc_full, fifo_level == `MRP_DESC_FIFO_DEPTH);
            if (desc_push && !desc_full) fifo_level = fifo_level + 1;
            meta_val_d = meta_val;

            if (meta_wait) begin
                check_bit("meta_val", meta_val, 1'b1);
                check_meta(meta_msg_id, meta_len, held_id, held_len);
            end
            if (meta_val && meta_rdy) begin
                if (exp_id_q.size() == 0) begin
                    fail_msg("metadata accepted with no descriptor pending");
                end else begin
                    check_meta(meta_msg_id, meta_len, exp_id_q.pop_front(), exp_len_q.pop_front());
                end
            end
            meta_wait = meta_val && !meta_rdy;
            held_id   = meta_msg_id;
            held_len  = meta_len;

            if (data_wait) begin
                check_bit("data_val", data_val, 1'b1);
                check_data(data, held_data);
            end
            if (data_val && data_rdy) begin
                if (exp_line_q.size() == 0) begin
                    fail_msg("data line accepted with no line expected");
                end else begin
                    check_data(data, exp_line_q.pop_front());
                    lines_seen = lines_seen + 1;
                end
            end
            data_wait = data_val && !data_rdy;
            held_data = data;
        end
    end

    // ********************
    // producer
    // ********************

    initial begin
        mrp_rx_out_pkg::addr_t   base;
        mrp_rx_out_pkg::addr_t   addr;
        mrp_rx_out_pkg::len_t    len;
        mrp_rx_out_pkg::msg_id_t id;
        logic [31:0]             r;
        logic [31:0]             word_hi;
        logic [31:0]             word_lo;
        int                      n;

        rst         = 1'b1;
        wr_en       = 1'b0;
        wr_addr     = '0;
        wr_data     = '0;
        desc_push   = 1'b0;
        desc_base   = '0;
        desc_len    = '0;
        desc_msg_id = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        base = '0;  // region rotates through the buffer
        for (int m = 0; m < NUM_MSGS; m++) begin
            r    = rand_word();
            len  = {1'b0, r[27:24]} + 5'd1;
            id   = r[23:16];
            n    = int'(len);
            addr = base;
            for (int i = 0; i < n; i++) begin
                @(posedge clk);
                word_hi = rand_word();
                word_lo = rand_word();
                wr_en   <= 1'b1;
                wr_addr <= addr;
                wr_data <= {word_hi, word_lo};
                model_mem[addr] = {word_hi, word_lo};
                addr = addr + 8'd1;
            end
            @(posedge clk);
            wr_en <= 1'b0;
            while (desc_full) @(posedge clk);
            desc_push   <= 1'b1;
            desc_base   <= base;
            desc_len    <= len;
            desc_msg_id <= id;
            exp_id_q.push_back(id);
            exp_len_q.push_back(len);
            addr = base;
            for (int i = 0; i < n; i++) begin
                exp_line_q.push_back(model_mem[addr]);
                addr = addr + 8'd1;
            end
            total_lines = total_lines + n;
            @(posedge clk);
            desc_push <= 1'b0;
            base = addr;
        end

        while (exp_id_q.size() != 0 || exp_line_q.size() != 0) @(posedge clk);
        repeat (10) @(negedge clk);  // catch stray transfers

        if (!meta_val && !data_val) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("outputs still valid after the last expected transfer");
            $display("Test failed");
            $fatal(1, "stray transfer pending");
        end
    end

endmodule

`default_nettype wire

/* mrp_rx_buffer_output.sv */
`default_nettype none

module mrp_rx_buffer_output (
    input  logic                     clk,
    input  logic                     rst,

    // producer writes
    input  logic                     wr_en,
    input  mrp_rx_out_pkg::addr_t    wr_addr,
    input  mrp_rx_out_pkg::line_t    wr_data,

    input  logic                     desc_push,
    input  mrp_rx_out_pkg::addr_t    desc_base,
    input  mrp_rx_out_pkg::len_t     desc_len,
    input  mrp_rx_out_pkg::msg_id_t  desc_msg_id,
    output logic                     desc_full,

    // destination
    output logic                     meta_val,
    input  logic                     meta_rdy,
    output mrp_rx_out_pkg::msg_id_t  meta_msg_id,
    output mrp_rx_out_pkg::len_t     meta_len,

    output logic                     data_val,
    input  logic                     data_rdy,
    output mrp_rx_out_pkg::line_t    data
);

    logic                    msg_desc_avail;
    logic                    msg_desc_req;
    mrp_rx_out_pkg::addr_t   head_base;
    mrp_rx_out_pkg::len_t    head_len;
    mrp_rx_out_pkg::msg_id_t head_msg_id;

    logic                    rd_req_val;
    mrp_rx_out_pkg::addr_t   rd_addr;

    logic                    init_state;
    logic                    incr_rd_addr;
    logic                    last_rd;

    mrp_rx_desc_fifo desc_fifo (
        .clk         (clk),
        .rst         (rst),
        .push        (desc_push),
        .push_base   (desc_base),
        .push_len    (desc_len),
        .push_msg_id (desc_msg_id),
        .pop         (msg_desc_req),
        .head_base   (head_base),
        .head_len    (head_len),
        .head_msg_id (head_msg_id),
        .avail       (msg_desc_avail),
        .full        (desc_full)
    );

    mrp_rx_buffer_mem buffer_mem (
        .clk        (clk),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .rd_req_val (rd_req_val),
        .rd_addr    (rd_addr),
        .rd_data    (data)
    );

    mrp_rx_buffer_output_ctrl output_ctrl (
        .clk            (clk),
        .rst            (rst),
        .msg_desc_avail (msg_desc_avail),
        .msg_desc_req   (msg_desc_req),
        .rd_req_val     (rd_req_val),
        .meta_val       (meta_val),
        .meta_rdy       (meta_rdy),
        .data_val       (data_val),
        .data_rdy       (data_rdy),
        .init_state     (init_state),
        .incr_rd_addr   (incr_rd_addr),
        .last_rd        (last_rd)
    );

    mrp_rx_buffer_output_datap output_datap (
        .clk          (clk),
        .rst          (rst),
        .init_state   (init_state),
        .incr_rd_addr (incr_rd_addr),
        .desc_base    (head_base),
        .desc_len     (head_len),
        .desc_msg_id  (head_msg_id),
        .rd_addr      (rd_addr),
        .last_rd      (last_rd),
        .meta_msg_id  (meta_msg_id),
        .meta_len     (meta_len)
    );

endmodule

`default_nettype wire

/* mrp_rx_buffer_output_datap.sv */
`default_nettype none

module mrp_rx_buffer_output_datap (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     init_state,
    input  logic                     incr_rd_addr,

    input  mrp_rx_out_pkg::addr_t    desc_base,
    input  mrp_rx_out_pkg::len_t     desc_len,
    input  mrp_rx_out_pkg::msg_id_t  desc_msg_id,

    output mrp_rx_out_pkg::addr_t    rd_addr,
    output logic                     last_rd,

    output mrp_rx_out_pkg::msg_id_t  meta_msg_id,
    output mrp_rx_out_pkg::len_t     meta_len
);

    mrp_rx_out_pkg::addr_t addr_reg;
    mrp_rx_out_pkg::addr_t addr_inc;
    mrp_rx_out_pkg::len_t  remain_reg;  // lines left after the current one

    assign addr_inc = addr_reg + 1'b1;  // wraps at 256

    // next line goes out in the same cycle as the accept
    assign rd_addr = incr_rd_addr ? addr_inc : addr_reg;
    assign last_rd = (remain_reg == '0);

    // ********************
    // line counters
    // ********************

    always_ff @(posedge clk) begin
        if (rst) begin
            addr_reg   <= '0;
            remain_reg <= '0;
        end else if (init_state) begin
            addr_reg   <= desc_base;
            remain_reg <= desc_len - 1'b1;
        end else if (incr_rd_addr) begin
            addr_reg   <= addr_inc;
            remain_reg <= remain_reg - 1'b1;
        end
    end

    // ********************
    // metadata hold
    // ********************

    // stable until the next pop, which waits for meta_rdy
    always_ff @(posedge clk) begin
        if (init_state) begin
            meta_msg_id <= desc_msg_id;
            meta_len    <= desc_len;
        end
    end

endmodule

`default_nettype wire

/* mrp_rx_buffer_output_ctrl.sv */
`default_nettype none

module mrp_rx_buffer_output_ctrl (
    input  logic clk,
    input  logic rst,

    input  logic msg_desc_avail,
    output logic msg_desc_req,

    output logic rd_req_val,

    output logic meta_val,
    input  logic meta_rdy,

    output logic data_val,
    input  logic data_rdy,

    output logic init_state,
    output logic incr_rd_addr,
    input  logic last_rd
);

    mrp_rx_out_pkg::ctrl_state_e state_reg;
    mrp_rx_out_pkg::ctrl_state_e state_next;

    mrp_rx_out_pkg::meta_state_e meta_state_reg;
    mrp_rx_out_pkg::meta_state_e meta_state_next;

    logic meta_start;  // descriptor taken this cycle

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg      <= mrp_rx_out_pkg::READY;
            meta_state_reg <= mrp_rx_out_pkg::WAITING;
        end else begin
            state_reg      <= state_next;
            meta_state_reg <= meta_state_next;
        end
    end

    // ********************
    // message output
    // ********************

    always_comb begin
        msg_desc_req = 1'b0;
        init_state   = 1'b0;
        rd_req_val   = 1'b0;
        incr_rd_addr = 1'b0;
        data_val     = 1'b0;
        meta_start   = 1'b0;
        state_next   = state_reg;

        case (state_reg)
            mrp_rx_out_pkg::READY: begin
                // metadata slot must be free before the next pop
                if (msg_desc_avail && (meta_state_reg == mrp_rx_out_pkg::WAITING)) begin
                    msg_desc_req = 1'b1;
                    init_state   = 1'b1;
                    meta_start   = 1'b1;
                    state_next   = mrp_rx_out_pkg::RD_FIRST_LINE;
                end
            end

            mrp_rx_out_pkg::RD_FIRST_LINE: begin
                rd_req_val = 1'b1;  // base line
                state_next = mrp_rx_out_pkg::OUTPUT_DATA;
            end

            mrp_rx_out_pkg::OUTPUT_DATA: begin
                data_val   = 1'b1;
                rd_req_val = 1'b1;  // re-read same line while stalled
                if (data_rdy) begin
                    incr_rd_addr = 1'b1;
                    if (last_rd) begin
                        state_next = mrp_rx_out_pkg::READY;
                    end
                end
            end

            default: begin
                state_next = mrp_rx_out_pkg::READY;
            end
        endcase
    end

    // ********************
    // metadata slot
    // ********************

    always_comb begin
        meta_val        = 1'b0;
        meta_state_next = meta_state_reg;

        case (meta_state_reg)
            mrp_rx_out_pkg::WAITING: begin
                if (meta_start) begin
                    meta_state_next = mrp_rx_out_pkg::META_OUT;
                end
            end

            mrp_rx_out_pkg::META_OUT: begin
                meta_val = 1'b1;
                if (meta_rdy) begin
                    meta_state_next = mrp_rx_out_pkg::WAITING;
                end
            end

            default: begin
                meta_state_next = mrp_rx_out_pkg::WAITING;
            end
        endcase
    end

endmodule

`default_nettype wire

/* mrp_rx_buffer_mem.sv */
`default_nettype none

`include "mrp_rx_out_cfg.svh"

module mrp_rx_buffer_mem (
    input  logic                   clk,

    input  logic                   wr_en,
    input  mrp_rx_out_pkg::addr_t  wr_addr,
    input  mrp_rx_out_pkg::line_t  wr_data,

    input  logic                   rd_req_val,
    input  mrp_rx_out_pkg::addr_t  rd_addr,
    output mrp_rx_out_pkg::line_t  rd_data
);

    localparam int LINES = 1 << `MRP_ADDR_W;

    // ********************
    // line storage
    // ********************

    mrp_rx_out_pkg::line_t mem [0:LINES-1];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // ********************
    // read port
    // ********************

    // output holds between requests
    always_ff @(posedge clk) begin
        if (rd_req_val) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

/* mrp_rx_desc_fifo.sv */
`default_nettype none

`include "mrp_rx_out_cfg.svh"

module mrp_rx_desc_fifo (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     push,
    input  mrp_rx_out_pkg::addr_t    push_base,
    input  mrp_rx_out_pkg::len_t     push_len,
    input  mrp_rx_out_pkg::msg_id_t  push_msg_id,

    input  logic                     pop,
    output mrp_rx_out_pkg::addr_t    head_base,
    output mrp_rx_out_pkg::len_t     head_len,
    output mrp_rx_out_pkg::msg_id_t  head_msg_id,

    output logic                     avail,
    output logic                     full
);

    localparam int PTR_W = $clog2(`MRP_DESC_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`MRP_DESC_FIFO_DEPTH + 1);
    localparam logic [CNT_W-1:0] DEPTH = CNT_W'(`MRP_DESC_FIFO_DEPTH);

    mrp_rx_out_pkg::addr_t   base_mem   [0:`MRP_DESC_FIFO_DEPTH-1];
    mrp_rx_out_pkg::len_t    len_mem    [0:`MRP_DESC_FIFO_DEPTH-1];
    mrp_rx_out_pkg::msg_id_t msg_id_mem [0:`MRP_DESC_FIFO_DEPTH-1];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic push_ok;
    logic pop_ok;

    assign push_ok = push & ~full;  // dropped when full
    assign pop_ok  = pop & avail;

    assign avail = (count != '0);
    assign full  = (count == DEPTH);

    // head is visible without a pop
    assign head_base   = base_mem[rd_ptr];
    assign head_len    = len_mem[rd_ptr];
    assign head_msg_id = msg_id_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push_ok) begin
            base_mem[wr_ptr]   <= push_base;
            len_mem[wr_ptr]    <= push_len;
            msg_id_mem[wr_ptr] <= push_msg_id;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle or push with pop
            endcase
        end
    end

endmodule

`default_nettype wire

/* mrp_rx_out_pkg.sv */
`default_nettype none

`include "mrp_rx_out_cfg.svh"

package mrp_rx_out_pkg;

    typedef logic [`MRP_LINE_W-1:0]   line_t;
    typedef logic [`MRP_ADDR_W-1:0]   addr_t;
    typedef logic [`MRP_LEN_W-1:0]    len_t;
    typedef logic [`MRP_MSG_ID_W-1:0] msg_id_t;

    // message output sequencing
    typedef enum logic [1:0] {
        READY         = 2'd0,
        RD_FIRST_LINE = 2'd1,
        OUTPUT_DATA   = 2'd2
    } ctrl_state_e;

    // metadata slot
    typedef enum logic {
        WAITING  = 1'b0,
        META_OUT = 1'b1
    } meta_state_e;

endpackage

`default_nettype wire

/* mrp_rx_out_cfg.svh */
`ifndef MRP_RX_OUT_CFG_SVH
`define MRP_RX_OUT_CFG_SVH

// ********************
// buffer geometry
// ********************

`define MRP_LINE_W          64  // one message line
`define MRP_ADDR_W          8   // 256 buffer lines

// ********************
// descriptor fields
// ********************

`define MRP_LEN_W           5   // line count, 1 to 16
`define MRP_MSG_ID_W        8

`define MRP_DESC_FIFO_DEPTH 4   // power of two

`endif
